// ==== verilog/mfifo_cfg_pkg.sv ====
////////////////////
// Sizes are fixed here and shared by every block and the testbench
// Widths must stay consistent with num_fifos and fifo_depth
////////////////////

package mfifo_cfg_pkg;

  // Logical FIFOs sharing the one RAM
  localparam int num_fifos = 4;
  // Shared RAM entries over all FIFOs
  localparam int fifo_depth = 8;
  // Item width
  localparam int data_width = 16;
  // Index widths
  localparam int fifo_id_width = 2;
  localparam int addr_width = 3;
  // Holds 0 to fifo_depth
  localparam int count_width = 4;

endpackage

// ==== verilog/mfifo_types_pkg.sv ====
////////////////////
// Flow types between the multi-FIFO blocks
// A valid field, where present, qualifies the rest of the struct
////////////////////

package mfifo_types_pkg;

  // Push payload from the source
  typedef struct packed {
    logic [mfifo_cfg_pkg::data_width-1:0]    data;
    logic [mfifo_cfg_pkg::fifo_id_width-1:0] fifo_id;
  } push_req_t;

  // One write into the data RAM
  typedef struct packed {
    logic                                 valid;
    logic [mfifo_cfg_pkg::addr_width-1:0] addr;
    logic [mfifo_cfg_pkg::data_width-1:0] data;
  } ram_wr_t;

  // New tail entry for one FIFO
  typedef struct packed {
    logic                                    valid;
    logic [mfifo_cfg_pkg::fifo_id_width-1:0] fifo_id;
    logic [mfifo_cfg_pkg::addr_width-1:0]    entry;
  } tail_upd_t;

  // RAM entry handed back to the free list
  typedef struct packed {
    logic                                 valid;
    logic [mfifo_cfg_pkg::addr_width-1:0] entry;
  } dealloc_t;

  // Output slot of one FIFO
  typedef enum logic [1:0] {slot_empty, slot_fetch, slot_full} slot_state_e;

endpackage

// ==== verilog/mfifo_freelist.sv ====
////////////////////
// Lowest free entry is offered first; a claim and a release may share a cycle
////////////////////

`timescale 1ns/10ps

module mfifo_freelist (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 alloc_take,
  output logic                                 alloc_avail,
  output logic [mfifo_cfg_pkg::addr_width-1:0] alloc_entry,
  input  mfifo_types_pkg::dealloc_t            dealloc
);

  // One bit per RAM entry, set when free
  logic [mfifo_cfg_pkg::fifo_depth-1:0] free_q;
  logic [mfifo_cfg_pkg::fifo_depth-1:0] free_d;

  assign alloc_avail = |free_q;

  // Priority pick scans down so the lowest index wins
  always_comb begin
    alloc_entry = '0;
    for (int i = mfifo_cfg_pkg::fifo_depth - 1; i >= 0; i--) begin
      if (free_q[i]) begin
        alloc_entry = mfifo_cfg_pkg::addr_width'(i);
      end
    end
  end

  // Claimed entry is always free and released entry is always in use
  // so the two never collide
  always_comb begin
    free_d = free_q;
    if (alloc_take) begin
      free_d[alloc_entry] = 1'b0;
    end
    if (dealloc.valid) begin
      free_d[dealloc.entry] = 1'b1;
    end
  end

  // All entries free out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      free_q <= '1;
    end else begin
      free_q <= free_d;
    end
  end

endmodule

// ==== verilog/mfifo_push_ctrl.sv ====
////////////////////
// Single push port; the source must hold push stable while push_ready is low
////////////////////

`timescale 1ns/10ps

module mfifo_push_ctrl (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       push_valid,
  input  mfifo_types_pkg::push_req_t push,
  output logic                       push_ready,
  output mfifo_types_pkg::ram_wr_t   ram_wr,
  output mfifo_types_pkg::tail_upd_t tail_upd,
  input  mfifo_types_pkg::dealloc_t  dealloc
);

  logic                                 accept;
  logic                                 alloc_avail;
  logic [mfifo_cfg_pkg::addr_width-1:0] alloc_entry;

  // Entry source for every accepted push
  mfifo_freelist u_freelist (
    .clk         (clk),
    .reset       (reset),
    .alloc_take  (accept),
    .alloc_avail (alloc_avail),
    .alloc_entry (alloc_entry),
    .dealloc     (dealloc)
  );

  // Ready only while a free entry exists
  assign push_ready = alloc_avail;
  assign accept     = push_valid & push_ready;

  // Payload lands in the claimed entry
  assign ram_wr = '{valid: accept, addr: alloc_entry, data: push.data};

  // Same entry becomes the new tail of the addressed FIFO
  assign tail_upd = '{valid: accept, fifo_id: push.fifo_id, entry: alloc_entry};

endmodule

// ==== verilog/mfifo_linked_list.sv ====
////////////////////
// Pops are only requested for non-empty FIFOs
// next_q entries are valid only behind a live entry
////////////////////

`timescale 1ns/10ps

module mfifo_linked_list (
  input  logic                                    clk,
  input  logic                                    reset,
  input  mfifo_types_pkg::tail_upd_t              tail_upd,
  input  logic                                    pop_req_valid,
  input  logic [mfifo_cfg_pkg::fifo_id_width-1:0] pop_req_fifo,
  output logic [mfifo_cfg_pkg::num_fifos-1:0]     fifo_nonempty,
  output logic [mfifo_cfg_pkg::num_fifos-1:0][mfifo_cfg_pkg::addr_width-1:0] fifo_head
);

  logic [mfifo_cfg_pkg::num_fifos-1:0][mfifo_cfg_pkg::addr_width-1:0]  head_q;
  logic [mfifo_cfg_pkg::num_fifos-1:0][mfifo_cfg_pkg::addr_width-1:0]  tail_q;
  logic [mfifo_cfg_pkg::num_fifos-1:0][mfifo_cfg_pkg::count_width-1:0] count_q;
  // Shared next-pointer table indexed by RAM entry
  logic [mfifo_cfg_pkg::addr_width-1:0] next_q [mfifo_cfg_pkg::fifo_depth];
  logic [mfifo_cfg_pkg::num_fifos-1:0]  push_hit;
  logic [mfifo_cfg_pkg::num_fifos-1:0]  pop_hit;

  // Decode push and pop per FIFO
  always_comb begin
    for (int f = 0; f < mfifo_cfg_pkg::num_fifos; f++) begin
      push_hit[f] = tail_upd.valid && (tail_upd.fifo_id == f);
      pop_hit[f]  = pop_req_valid && (pop_req_fifo == f);
      fifo_nonempty[f] = (count_q[f] != '0);
    end
  end

  assign fifo_head = head_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      for (int f = 0; f < mfifo_cfg_pkg::num_fifos; f++) begin
        if (push_hit[f]) begin
          tail_q[f] <= tail_upd.entry;
        end
        // Pushed entry becomes head when the list is empty after this edge,
        // since its link from the old tail is not written yet
        if (push_hit[f] && ((count_q[f] == '0) ||
            ((count_q[f] == mfifo_cfg_pkg::count_width'(1)) && pop_hit[f]))) begin
          head_q[f] <= tail_upd.entry;
        end else if (pop_hit[f]) begin
          head_q[f] <= next_q[head_q[f]];
        end
        case ({push_hit[f], pop_hit[f]})
          2'b10:   count_q[f] <= count_q[f] + mfifo_cfg_pkg::count_width'(1);
          2'b01:   count_q[f] <= count_q[f] - mfifo_cfg_pkg::count_width'(1);
          default: count_q[f] <= count_q[f];
        endcase
      end
    end
  end

  // Link behind the old tail only while that tail belongs to this FIFO
  always_ff @(posedge clk) begin
    if (tail_upd.valid && (count_q[tail_upd.fifo_id] != '0)) begin
      next_q[tail_q[tail_upd.fifo_id]] <= tail_upd.entry;
    end
  end

endmodule

// ==== verilog/mfifo_data_ram.sv ====
////////////////////
// One write and one read port; read data is valid one cycle after rd_en
////////////////////

`timescale 1ns/10ps

module mfifo_data_ram (
  input  logic                                 clk,
  input  mfifo_types_pkg::ram_wr_t             ram_wr,
  input  logic                                 rd_en,
  input  logic [mfifo_cfg_pkg::addr_width-1:0] rd_addr,
  output logic [mfifo_cfg_pkg::data_width-1:0] rd_data
);

  // Shared item storage
  logic [mfifo_cfg_pkg::data_width-1:0] mem [mfifo_cfg_pkg::fifo_depth];

  always_ff @(posedge clk) begin
    if (ram_wr.valid) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
  end

  // Read address is a live entry, never the one being written
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== verilog/mfifo_pop_ctrl.sv ====
////////////////////
// At most one fetch is in flight, so a slot in slot_fetch owns rd_data
////////////////////

`timescale 1ns/10ps

module mfifo_pop_ctrl (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic [mfifo_cfg_pkg::num_fifos-1:0]     fifo_nonempty,
  input  logic [mfifo_cfg_pkg::num_fifos-1:0][mfifo_cfg_pkg::addr_width-1:0] fifo_head,
  output logic                                    pop_req_valid,
  output logic [mfifo_cfg_pkg::fifo_id_width-1:0] pop_req_fifo,
  output logic                                    rd_en,
  output logic [mfifo_cfg_pkg::addr_width-1:0]    rd_addr,
  input  logic [mfifo_cfg_pkg::data_width-1:0]    rd_data,
  output mfifo_types_pkg::dealloc_t               dealloc,
  output logic [mfifo_cfg_pkg::num_fifos-1:0]     pop_valid,
  input  logic [mfifo_cfg_pkg::num_fifos-1:0]     pop_ready,
  output logic [mfifo_cfg_pkg::num_fifos-1:0][mfifo_cfg_pkg::data_width-1:0] pop_data
);

  mfifo_types_pkg::slot_state_e slot_state_q [mfifo_cfg_pkg::num_fifos];
  logic [mfifo_cfg_pkg::num_fifos-1:0][mfifo_cfg_pkg::data_width-1:0] slot_data_q;
  logic [mfifo_cfg_pkg::fifo_id_width-1:0] rr_ptr_q;
  logic [mfifo_cfg_pkg::fifo_id_width-1:0] pick;
  logic [mfifo_cfg_pkg::fifo_id_width-1:0] idx;
  logic [mfifo_cfg_pkg::num_fifos-1:0]     eligible;
  logic                                    fetch;

  // Candidate FIFOs have entries waiting and room in the slot
  always_comb begin
    for (int f = 0; f < mfifo_cfg_pkg::num_fifos; f++) begin
      eligible[f]  = fifo_nonempty[f] && (slot_state_q[f] == mfifo_types_pkg::slot_empty);
      pop_valid[f] = (slot_state_q[f] == mfifo_types_pkg::slot_full);
    end
  end

  // Round-robin search starting at the pointer
  always_comb begin
    pick  = rr_ptr_q;
    idx   = rr_ptr_q;
    fetch = 1'b0;
    for (int i = 0; i < mfifo_cfg_pkg::num_fifos; i++) begin
      idx = rr_ptr_q + mfifo_cfg_pkg::fifo_id_width'(i);
      if (!fetch && eligible[idx]) begin
        pick  = idx;
        fetch = 1'b1;
      end
    end
  end

  // Read, free and unlink the head in the same cycle
  assign pop_req_valid = fetch;
  assign pop_req_fifo  = pick;
  assign rd_en         = fetch;
  assign rd_addr       = fifo_head[pick];
  assign dealloc       = '{valid: fetch, entry: fifo_head[pick]};
  assign pop_data      = slot_data_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      rr_ptr_q <= '0;
      for (int f = 0; f < mfifo_cfg_pkg::num_fifos; f++) begin
        slot_state_q[f] <= mfifo_types_pkg::slot_empty;
      end
    end else begin
      // Next search starts just past the winner
      if (fetch) begin
        rr_ptr_q <= pick + mfifo_cfg_pkg::fifo_id_width'(1);
      end
      for (int f = 0; f < mfifo_cfg_pkg::num_fifos; f++) begin
        case (slot_state_q[f])
          mfifo_types_pkg::slot_empty: begin
            if (fetch && (pick == f)) begin
              slot_state_q[f] <= mfifo_types_pkg::slot_fetch;
            end
          end
          mfifo_types_pkg::slot_fetch: slot_state_q[f] <= mfifo_types_pkg::slot_full;
          default: begin
            if (pop_ready[f]) begin
              slot_state_q[f] <= mfifo_types_pkg::slot_empty;
            end
          end
        endcase
      end
    end
  end

  // Slot payload captures the registered RAM read
  always_ff @(posedge clk) begin
    for (int f = 0; f < mfifo_cfg_pkg::num_fifos; f++) begin
      if (slot_state_q[f] == mfifo_types_pkg::slot_fetch) begin
        slot_data_q[f] <= rd_data;
      end
    end
  end

endmodule

// ==== verilog/mfifo_top.sv ====
////////////////////
// Four logical FIFOs share eight entries; each FIFO has its own pop port
////////////////////

`timescale 1ns/10ps

module mfifo_top (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                push_valid,
  input  mfifo_types_pkg::push_req_t          push,
  output logic                                push_ready,
  output logic [mfifo_cfg_pkg::num_fifos-1:0] pop_valid,
  input  logic [mfifo_cfg_pkg::num_fifos-1:0] pop_ready,
  output logic [mfifo_cfg_pkg::num_fifos-1:0][mfifo_cfg_pkg::data_width-1:0] pop_data
);

  mfifo_types_pkg::ram_wr_t                                           ram_wr;
  mfifo_types_pkg::tail_upd_t                                         tail_upd;
  mfifo_types_pkg::dealloc_t                                          dealloc;
  logic [mfifo_cfg_pkg::num_fifos-1:0]                                fifo_nonempty;
  logic [mfifo_cfg_pkg::num_fifos-1:0][mfifo_cfg_pkg::addr_width-1:0] fifo_head;
  logic                                                               pop_req_valid;
  logic [mfifo_cfg_pkg::fifo_id_width-1:0]                            pop_req_fifo;
  logic                                                               rd_en;
  logic [mfifo_cfg_pkg::addr_width-1:0]                               rd_addr;
  logic [mfifo_cfg_pkg::data_width-1:0]                               rd_data;

  // Allocation and RAM write
  mfifo_push_ctrl u_push_ctrl (
    .clk        (clk),
    .reset      (reset),
    .push_valid (push_valid),
    .push       (push),
    .push_ready (push_ready),
    .ram_wr     (ram_wr),
    .tail_upd   (tail_upd),
    .dealloc    (dealloc)
  );

  // Per-FIFO ordering
  mfifo_linked_list u_linked_list (
    .clk           (clk),
    .reset         (reset),
    .tail_upd      (tail_upd),
    .pop_req_valid (pop_req_valid),
    .pop_req_fifo  (pop_req_fifo),
    .fifo_nonempty (fifo_nonempty),
    .fifo_head     (fifo_head)
  );

  mfifo_data_ram u_data_ram (
    .clk     (clk),
    .ram_wr  (ram_wr),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // Head fetch and output slots
  mfifo_pop_ctrl u_pop_ctrl (
    .clk           (clk),
    .reset         (reset),
    .fifo_nonempty (fifo_nonempty),
    .fifo_head     (fifo_head),
    .pop_req_valid (pop_req_valid),
    .pop_req_fifo  (pop_req_fifo),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .dealloc       (dealloc),
    .pop_valid     (pop_valid),
    .pop_ready     (pop_ready),
    .pop_data      (pop_data)
  );

endmodule

// ==== test/mfifo_tb.sv ====
////////////////////
// Random traffic from a fixed LCG seed; a per-FIFO queue model checks every pop
////////////////////

`timescale 1ns/10ps

module mfifo_tb;

  localparam int random_cycles   = 1000;
  localparam int capacity_cycles = 40;
  localparam int mix_cycles      = 800;
  localparam int drain_budget    = 100;
  // Twice the sum of reset, traffic phase and drain lengths
  localparam int timeout_limit =
    2 * (16 + random_cycles + capacity_cycles + mix_cycles + 3 * drain_budget);

  logic                                                               clk;
  logic                                                               reset;
  logic                                                               push_valid;
  mfifo_types_pkg::push_req_t                                         push;
  logic                                                               push_ready;
  logic [mfifo_cfg_pkg::num_fifos-1:0]                                pop_valid;
  logic [mfifo_cfg_pkg::num_fifos-1:0]                                pop_ready;
  logic [mfifo_cfg_pkg::num_fifos-1:0][mfifo_cfg_pkg::data_width-1:0] pop_data;

  // Reference model with one queue of pending items per FIFO
  logic [mfifo_cfg_pkg::data_width-1:0] model_q [mfifo_cfg_pkg::num_fifos][$];
  logic [31:0] lcg_state = 32'd90;
  int          error_count = 0;
  int          check_count = 0;
  int          accept_count = 0;
  int          cycle_count = 0;
  // Set while a refused push must stay on the port
  logic        hold = 1'b0;
  string       phase_name = "reset";

  mfifo_top uut (
    .clk        (clk),
    .reset      (reset),
    .push_valid (push_valid),
    .push       (push),
    .push_ready (push_ready),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .pop_data   (pop_data)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // Numerical Recipes constants
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic chance(input int pct);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:16] % 16'd100) < pct;
  endfunction

  function automatic mfifo_types_pkg::push_req_t random_push(input logic [1:0] id_mask);
    logic [31:0]                r;
    mfifo_types_pkg::push_req_t p;
    r = next_rand();
    p.data    = r[31:16];
    p.fifo_id = r[13:12] & id_mask;
    return p;
  endfunction

  function automatic logic [3:0] random_ready(input int pct);
    logic [3:0] r;
    for (int f = 0; f < mfifo_cfg_pkg::num_fifos; f++) begin
      r[f] = chance(pct);
    end
    return r;
  endfunction

  function automatic int model_total();
    int n;
    n = 0;
    for (int f = 0; f < mfifo_cfg_pkg::num_fifos; f++) begin
      n += model_q[f].size();
    end
    return n;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    assert (expected == actual) else begin
      error_count++;
      $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // Sampled mid-cycle, so inputs and outputs are settled for the coming edge
  task automatic observe();
    logic [mfifo_cfg_pkg::data_width-1:0] expected;
    for (int f = 0; f < mfifo_cfg_pkg::num_fifos; f++) begin
      if (pop_valid[f]) begin
        check_count++;
        assert (model_q[f].size() != 0) else begin
          error_count++;
          $display("%s: pop_valid on FIFO %0d with no item pushed to it", phase_name, f);
        end
        if (pop_ready[f] && (model_q[f].size() != 0)) begin
          expected = model_q[f].pop_front();
          check_value($sformatf("%s pop fifo %0d", phase_name, f), 32'(expected),
                      32'(pop_data[f]));
        end
      end
    end
    // Pops first, so a push in this cycle cannot hide a phantom item
    hold = push_valid && !push_ready;
    if (push_valid && push_ready) begin
      model_q[push.fifo_id].push_back(push.data);
      accept_count++;
    end
  endtask

  task automatic run_cycle(input logic pv, input mfifo_types_pkg::push_req_t p,
                           input logic [3:0] pr);
    @(posedge clk);
    #2;
    if (!hold) begin
      push_valid = pv;
      push       = p;
    end
    pop_ready = pr;
    @(negedge clk);
    observe();
  endtask

  // Pops everything the model holds, including a push still waiting on the port
  task automatic drain_all();
    while ((model_total() != 0) || push_valid) begin
      run_cycle(1'b0, '0, '1);
    end
    // One idle cycle lets the last pop handshake complete
    run_cycle(1'b0, '0, '0);
  endtask

  initial begin
    mfifo_types_pkg::push_req_t p;
    int                         prev_count;
    reset      = 1'b1;
    push_valid = 1'b0;
    push       = '0;
    pop_ready  = '0;
    repeat (16) @(posedge clk);
    #2 reset = 1'b0;
    @(negedge clk);
    check_value("reset push_ready", 32'd1, 32'(push_ready));
    check_value("reset pop_valid", 32'd0, 32'(pop_valid));

    // Heavy pushing first, then heavy popping
    phase_name = "random";
    for (int i = 0; i < random_cycles; i++) begin
      if (i < random_cycles / 2) begin
        run_cycle(chance(70), random_push(2'b11), random_ready(30));
      end else begin
        run_cycle(chance(40), random_push(2'b11), random_ready(70));
      end
    end
    drain_all();

    // One item per FIFO first fills every slot while all pops stall
    phase_name = "capacity";
    accept_count = 0;
    for (int i = 0; i < capacity_cycles; i++) begin
      prev_count = accept_count;
      p = random_push(2'b11);
      if (accept_count < mfifo_cfg_pkg::num_fifos) begin
        p.fifo_id = mfifo_cfg_pkg::fifo_id_width'(accept_count);
      end
      run_cycle(1'b1, p, '0);
      if (prev_count >= mfifo_cfg_pkg::fifo_depth + mfifo_cfg_pkg::num_fifos) begin
        check_count++;
        assert (!push_ready) else begin
          error_count++;
          $display("capacity: push_ready rose again while every pop was stalled");
        end
      end
    end
    check_value("capacity accepted pushes",
                32'(mfifo_cfg_pkg::fifo_depth + mfifo_cfg_pkg::num_fifos),
                32'(accept_count));

    phase_name = "recovery";
    drain_all();
    check_value("recovery push_ready", 32'd1, 32'(push_ready));
    check_value("recovery pop_valid", 32'd0, 32'(pop_valid));

    // Two busy FIFOs with fast pops, so a push often meets a fetch at count 1
    phase_name = "interleave";
    repeat (mix_cycles) run_cycle(chance(50), random_push(2'b01), random_ready(85));
    drain_all();

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    while (cycle_count < timeout_limit) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", timeout_limit);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== all.f ====
verilog/mfifo_cfg_pkg.sv
verilog/mfifo_types_pkg.sv
verilog/mfifo_freelist.sv
verilog/mfifo_push_ctrl.sv
verilog/mfifo_linked_list.sv
verilog/mfifo_data_ram.sv
verilog/mfifo_pop_ctrl.sv
verilog/mfifo_top.sv
test/mfifo_tb.sv

// ==== Makefile ====
# Verilator build and run for the shared multi-FIFO testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= mfifo_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Pass only when the pass message stands alone on a line of the log
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
